/* rtl/cu_router_pkg.sv */
////////////////////////////////////////////////////////////
// Shared sizes for the CU router
// CU count and tag width, payload widths
// Fifo depths and almost full margin
////////////////////////////////////////////////////////////

`default_nettype none

package cu_router_pkg;

	////////////////////////////////////////////////////////////
	// Compute units
	////////////////////////////////////////////////////////////

	localparam int num_cu = 4;
	// Tag carried with each read command
	localparam int cu_id_bits = $clog2(num_cu);

	////////////////////////////////////////////////////////////
	// Payload widths
	////////////////////////////////////////////////////////////

	localparam int vertex_job_bits    = 32;
	localparam int read_address_bits  = 32;
	localparam int response_data_bits = 32;

	////////////////////////////////////////////////////////////
	// Buffering
	////////////////////////////////////////////////////////////

	localparam int vertex_fifo_depth  = 8;
	localparam int command_fifo_depth = 8;
	// Free entries left when a fifo stops accepting
	localparam int fifo_margin = 2;

endpackage

`default_nettype wire

/* rtl/vertex_job_dispatch.sv */
////////////////////////////////////////////////////////////
// Vertex job dispatcher
// Job fifo, pending request bits per CU
// Round-robin choice of the lane that gets the next job
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module vertex_job_dispatch (
	input  logic                                      clock,
	input  logic                                      rstn,
	input  logic                                      vertex_job_valid,
	input  logic [cu_router_pkg::vertex_job_bits-1:0] vertex_job,
	input  logic [cu_router_pkg::num_cu-1:0]          job_request,
	output logic                                      vertex_job_ready,
	output logic [cu_router_pkg::num_cu-1:0]          dispatch_valid,
	output logic [cu_router_pkg::vertex_job_bits-1:0] dispatch_job
);
	import cu_router_pkg::*;

	localparam int ptr_bits   = $clog2(vertex_fifo_depth);
	localparam int count_bits = ptr_bits + 1;

	logic [vertex_job_bits-1:0] job_mem [0:vertex_fifo_depth-1];
	logic [ptr_bits-1:0]        write_ptr;
	logic [ptr_bits-1:0]        read_ptr;
	logic [count_bits-1:0]      job_count;
	logic                       push;
	logic                       pop;
	logic [num_cu-1:0]          pending;
	logic [cu_id_bits-1:0]      last_lane;
	logic                       pick_valid;
	logic [cu_id_bits-1:0]      pick_lane;
	logic [num_cu-1:0]          served;

	////////////////////////////////////////////////////////////
	// Job fifo
	////////////////////////////////////////////////////////////

	assign push = vertex_job_valid && (job_count != count_bits'(vertex_fifo_depth));
	// Pop only when a lane is served
	assign pop  = pick_valid && (job_count != '0);

	assign vertex_job_ready =
		(count_bits'(vertex_fifo_depth) - job_count) > count_bits'(fifo_margin);

	always_ff @(posedge clock) begin
		if (push) begin
			job_mem[write_ptr] <= vertex_job;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_ptr <= '0;
			read_ptr  <= '0;
			job_count <= '0;
		end else begin
			if (push) begin
				write_ptr <= write_ptr + 1'b1;
			end
			if (pop) begin
				read_ptr <= read_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   job_count <= job_count + 1'b1;
				2'b01:   job_count <= job_count - 1'b1;
				default: job_count <= job_count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Round-robin lane choice
	////////////////////////////////////////////////////////////

	// Search starts one lane past the last one served
	always_comb begin : pick_next_lane
		int lane_index;
		pick_valid = 1'b0;
		pick_lane  = last_lane;
		for (int offset = 1; offset <= num_cu; offset++) begin
			lane_index = (int'(last_lane) + offset) % num_cu;
			if (!pick_valid && pending[lane_index]) begin
				pick_valid = 1'b1;
				pick_lane  = cu_id_bits'(lane_index);
			end
		end
	end

	assign served = pop ? (num_cu'(1) << pick_lane) : '0;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pending        <= '0;
			last_lane      <= cu_id_bits'(num_cu - 1);
			dispatch_valid <= '0;
		end else begin
			// A request arriving on the served lane stays pending
			pending        <= (pending & ~served) | job_request;
			dispatch_valid <= served;
			if (pop) begin
				last_lane <= pick_lane;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			dispatch_job <= job_mem[read_ptr];
		end
	end

endmodule

`default_nettype wire

/* rtl/cu_port.sv */
////////////////////////////////////////////////////////////
// Per-CU port
// One-entry read command slot, tagged response capture
// Job delivery register toward the CU
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cu_port #(
	parameter int port_index = 0
) (
	input  logic                                         clock,
	input  logic                                         rstn,
	input  logic                                         dispatch_valid,
	input  logic [cu_router_pkg::vertex_job_bits-1:0]    dispatch_job,
	input  logic                                         command_request,
	input  logic [cu_router_pkg::read_address_bits-1:0]  command_address,
	input  logic                                         grant,
	input  logic                                         response_valid,
	input  logic [cu_router_pkg::cu_id_bits-1:0]         response_cu_id,
	input  logic [cu_router_pkg::response_data_bits-1:0] response_data,
	output logic                                         job_valid,
	output logic [cu_router_pkg::vertex_job_bits-1:0]    job,
	output logic                                         command_ready,
	output logic                                         slot_full,
	output logic [cu_router_pkg::read_address_bits-1:0]  slot_address,
	output logic                                         cu_response_valid,
	output logic [cu_router_pkg::response_data_bits-1:0] cu_response_data
);
	import cu_router_pkg::*;

	logic slot_load;
	logic tag_match;

	assign slot_load     = command_request && !slot_full;
	assign command_ready = !slot_full;
	assign tag_match     = response_valid && (response_cu_id == cu_id_bits'(port_index));

	////////////////////////////////////////////////////////////
	// Control state
	////////////////////////////////////////////////////////////

	// Grant only arrives while the slot is full
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			slot_full         <= 1'b0;
			job_valid         <= 1'b0;
			cu_response_valid <= 1'b0;
		end else begin
			if (slot_load) begin
				slot_full <= 1'b1;
			end else if (grant) begin
				slot_full <= 1'b0;
			end
			job_valid         <= dispatch_valid;
			cu_response_valid <= tag_match;
		end
	end

	////////////////////////////////////////////////////////////
	// Payload
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (slot_load) begin
			slot_address <= command_address;
		end
		if (dispatch_valid) begin
			job <= dispatch_job;
		end
		if (tag_match) begin
			cu_response_data <= response_data;
		end
	end

endmodule

`default_nettype wire

/* rtl/read_command_arbiter.sv */
////////////////////////////////////////////////////////////
// Read command arbiter
// Round-robin grant among full command slots
// Burst fifo of address and tag, bus request/grant
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module read_command_arbiter (
	input  logic                                        clock,
	input  logic                                        rstn,
	input  logic [cu_router_pkg::num_cu-1:0]            slot_full,
	input  logic [cu_router_pkg::read_address_bits-1:0] slot_address [0:cu_router_pkg::num_cu-1],
	input  logic                                        bus_grant,
	output logic [cu_router_pkg::num_cu-1:0]            grant,
	output logic                                        bus_request,
	output logic                                        read_command_valid,
	output logic [cu_router_pkg::read_address_bits-1:0] read_command_address,
	output logic [cu_router_pkg::cu_id_bits-1:0]        read_command_cu_id
);
	import cu_router_pkg::*;

	localparam int ptr_bits   = $clog2(command_fifo_depth);
	localparam int count_bits = ptr_bits + 1;
	// Tag in the upper bits, address below
	localparam int entry_bits = cu_id_bits + read_address_bits;

	logic [entry_bits-1:0] command_mem [0:command_fifo_depth-1];
	logic [ptr_bits-1:0]   write_ptr;
	logic [ptr_bits-1:0]   read_ptr;
	logic [count_bits-1:0] command_count;
	logic                  almost_full;
	logic                  push;
	logic                  pop;
	logic [cu_id_bits-1:0] last_lane;
	logic                  pick_valid;
	logic [cu_id_bits-1:0] pick_lane;

	////////////////////////////////////////////////////////////
	// Slot arbitration
	////////////////////////////////////////////////////////////

	always_comb begin : pick_next_slot
		int lane_index;
		pick_valid = 1'b0;
		pick_lane  = last_lane;
		for (int offset = 1; offset <= num_cu; offset++) begin
			lane_index = (int'(last_lane) + offset) % num_cu;
			if (!pick_valid && slot_full[lane_index]) begin
				pick_valid = 1'b1;
				pick_lane  = cu_id_bits'(lane_index);
			end
		end
	end

	assign almost_full =
		(count_bits'(command_fifo_depth) - command_count) <= count_bits'(fifo_margin);

	// Granted slot is pushed on the same edge that empties it
	assign push  = pick_valid && !almost_full;
	assign grant = push ? (num_cu'(1) << pick_lane) : '0;

	////////////////////////////////////////////////////////////
	// Burst fifo
	////////////////////////////////////////////////////////////

	assign bus_request = (command_count != '0);
	assign pop         = bus_grant && bus_request;

	always_ff @(posedge clock) begin
		if (push) begin
			command_mem[write_ptr] <= {pick_lane, slot_address[pick_lane]};
		end
		if (pop) begin
			{read_command_cu_id, read_command_address} <= command_mem[read_ptr];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_ptr          <= '0;
			read_ptr           <= '0;
			command_count      <= '0;
			last_lane          <= cu_id_bits'(num_cu - 1);
			read_command_valid <= 1'b0;
		end else begin
			if (push) begin
				write_ptr <= write_ptr + 1'b1;
				last_lane <= pick_lane;
			end
			if (pop) begin
				read_ptr <= read_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   command_count <= command_count + 1'b1;
				2'b01:   command_count <= command_count - 1'b1;
				default: command_count <= command_count;
			endcase
			// Popped entry shows for one cycle
			read_command_valid <= pop;
		end
	end

endmodule

`default_nettype wire

/* rtl/cu_router_top.sv */
////////////////////////////////////////////////////////////
// CU router top level
// Dispatcher, one port per CU, read command arbiter
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cu_router_top (
	input  logic                                         clock,
	input  logic                                         rstn,
	input  logic                                         vertex_job_valid,
	input  logic [cu_router_pkg::vertex_job_bits-1:0]    vertex_job,
	output logic                                         vertex_job_ready,
	input  logic [cu_router_pkg::num_cu-1:0]             job_request,
	output logic [cu_router_pkg::num_cu-1:0]             job_valid,
	output logic [cu_router_pkg::vertex_job_bits-1:0]    job [0:cu_router_pkg::num_cu-1],
	input  logic [cu_router_pkg::num_cu-1:0]             command_request,
	input  logic [cu_router_pkg::read_address_bits-1:0]
		command_address [0:cu_router_pkg::num_cu-1],
	output logic [cu_router_pkg::num_cu-1:0]             command_ready,
	output logic                                         bus_request,
	input  logic                                         bus_grant,
	output logic                                         read_command_valid,
	output logic [cu_router_pkg::read_address_bits-1:0]  read_command_address,
	output logic [cu_router_pkg::cu_id_bits-1:0]         read_command_cu_id,
	input  logic                                         response_valid,
	input  logic [cu_router_pkg::cu_id_bits-1:0]         response_cu_id,
	input  logic [cu_router_pkg::response_data_bits-1:0] response_data,
	output logic [cu_router_pkg::num_cu-1:0]             cu_response_valid,
	output logic [cu_router_pkg::response_data_bits-1:0]
		cu_response_data [0:cu_router_pkg::num_cu-1]
);
	import cu_router_pkg::*;

	logic [num_cu-1:0]            dispatch_valid;
	logic [vertex_job_bits-1:0]   dispatch_job;
	logic [num_cu-1:0]            slot_full;
	logic [read_address_bits-1:0] slot_address [0:num_cu-1];
	logic [num_cu-1:0]            grant;

	vertex_job_dispatch dispatch0 (
		.clock           (clock),
		.rstn            (rstn),
		.vertex_job_valid(vertex_job_valid),
		.vertex_job      (vertex_job),
		.job_request     (job_request),
		.vertex_job_ready(vertex_job_ready),
		.dispatch_valid  (dispatch_valid),
		.dispatch_job    (dispatch_job)
	);

	// One port per CU, lane number is the tag
	for (genvar lane = 0; lane < num_cu; lane++) begin : gen_cu_port
		cu_port #(
			.port_index(lane)
		) port0 (
			.clock            (clock),
			.rstn             (rstn),
			.dispatch_valid   (dispatch_valid[lane]),
			.dispatch_job     (dispatch_job),
			.command_request  (command_request[lane]),
			.command_address  (command_address[lane]),
			.grant            (grant[lane]),
			.response_valid   (response_valid),
			.response_cu_id   (response_cu_id),
			.response_data    (response_data),
			.job_valid        (job_valid[lane]),
			.job              (job[lane]),
			.command_ready    (command_ready[lane]),
			.slot_full        (slot_full[lane]),
			.slot_address     (slot_address[lane]),
			.cu_response_valid(cu_response_valid[lane]),
			.cu_response_data (cu_response_data[lane])
		);
	end

	read_command_arbiter arbiter0 (
		.clock               (clock),
		.rstn                (rstn),
		.slot_full           (slot_full),
		.slot_address        (slot_address),
		.bus_grant           (bus_grant),
		.grant               (grant),
		.bus_request         (bus_request),
		.read_command_valid  (read_command_valid),
		.read_command_address(read_command_address),
		.read_command_cu_id  (read_command_cu_id)
	);

endmodule

`default_nettype wire

/* tests/cu_router_checker.sv */
////////////////////////////////////////////////////////////
// Checker for the CU router testbench
// Expected job, command and response flow from the ports
// Error and check counters, leftover check at end of run
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module cu_router_checker (
	input  logic                                         clock,
	input  logic                                         rstn,
	input  logic                                         vertex_job_valid,
	input  logic [cu_router_pkg::vertex_job_bits-1:0]    vertex_job,
	input  logic                                         vertex_job_ready,
	input  logic [cu_router_pkg::num_cu-1:0]             job_request,
	input  logic [cu_router_pkg::num_cu-1:0]             job_valid,
	input  logic [cu_router_pkg::vertex_job_bits-1:0]    job [0:cu_router_pkg::num_cu-1],
	input  logic [cu_router_pkg::num_cu-1:0]             command_request,
	input  logic [cu_router_pkg::read_address_bits-1:0]
		command_address [0:cu_router_pkg::num_cu-1],
	input  logic [cu_router_pkg::num_cu-1:0]             command_ready,
	input  logic                                         bus_request,
	input  logic                                         bus_grant,
	input  logic                                         read_command_valid,
	input  logic [cu_router_pkg::read_address_bits-1:0]  read_command_address,
	input  logic [cu_router_pkg::cu_id_bits-1:0]         read_command_cu_id,
	input  logic                                         response_valid,
	input  logic [cu_router_pkg::cu_id_bits-1:0]         response_cu_id,
	input  logic [cu_router_pkg::response_data_bits-1:0] response_data,
	input  logic [cu_router_pkg::num_cu-1:0]             cu_response_valid,
	input  logic [cu_router_pkg::response_data_bits-1:0]
		cu_response_data [0:cu_router_pkg::num_cu-1],
	input  logic                                         drain_done,
	output int                                           error_count,
	output int                                           check_count,
	output logic                                         report_done
);
	import cu_router_pkg::*;

	// Tag in the upper bits, address below
	localparam int entry_bits = cu_id_bits + read_address_bits;

	logic [vertex_job_bits-1:0]    job_queue [$];
	logic [entry_bits-1:0]         command_queue [$];
	int                            request_total [num_cu];
	int                            delivered_total [num_cu];
	int                            accepted_total;
	int                            accepted_before;
	int                            pop_total;
	logic                          pop_pending;
	logic [num_cu-1:0]             loaded_lanes;
	logic                          response_pending;
	logic [cu_id_bits-1:0]         response_tag;
	logic [response_data_bits-1:0] response_value;

	initial begin
		error_count = 0;
		check_count = 0;
		report_done = 1'b0;
	end

	task automatic check_value(input logic ok, input string message);
		check_count++;
		if (ok !== 1'b1) begin
			error_count++;
			$display("Fail %0t: %s", $time, message);
		end
	endtask

	task automatic report_problem(input string message);
		check_count++;
		error_count++;
		$display("%s", message);
	endtask

	task automatic clear_model();
		job_queue.delete();
		command_queue.delete();
		for (int lane = 0; lane < num_cu; lane++) begin
			request_total[lane]   = 0;
			delivered_total[lane] = 0;
		end
		accepted_total   = 0;
		accepted_before  = 0;
		pop_total        = 0;
		pop_pending      = 1'b0;
		loaded_lanes     = '0;
		response_pending = 1'b0;
	endtask

	task automatic check_reset_state();
		check_value(vertex_job_ready === 1'b1, "vertex_job_ready low in reset");
		check_value(command_ready === '1, "command_ready low in reset");
		check_value(job_valid === '0, "job_valid high in reset");
		check_value(cu_response_valid === '0, "cu_response_valid high in reset");
		check_value(read_command_valid === 1'b0, "read_command_valid high in reset");
		check_value(bus_request === 1'b0, "bus_request high in reset");
	endtask

	////////////////////////////////////////////////////////////
	// Per-cycle checks
	////////////////////////////////////////////////////////////

	task automatic check_jobs();
		logic [vertex_job_bits-1:0] expected;
		check_value($onehot0(job_valid),
			$sformatf("job_valid %b on several lanes", job_valid));
		for (int lane = 0; lane < num_cu; lane++) begin
			if (job_valid[lane] === 1'b1) begin
				delivered_total[lane]++;
				check_value(delivered_total[lane] <= request_total[lane],
					$sformatf("lane %0d got more jobs than it requested", lane));
				if (job_queue.size() == 0) begin
					report_problem(
						$sformatf("Lane %0d received a job that was never pushed", lane));
				end else begin
					expected = job_queue.pop_front();
					check_value(job[lane] === expected,
						$sformatf("lane %0d job %h, expected %h", lane, job[lane], expected));
				end
			end
		end
	endtask

	task automatic check_commands();
		int   match;
		logic request_expected;
		// Fifo holds something exactly when a command accepted two cycles back is not popped
		request_expected = accepted_before > pop_total;
		check_value(read_command_valid === pop_pending,
			$sformatf("read_command_valid %b, expected %b", read_command_valid, pop_pending));
		check_value(bus_request === request_expected,
			$sformatf("bus_request %b, expected %b", bus_request, request_expected));
		for (int lane = 0; lane < num_cu; lane++) begin
			if (loaded_lanes[lane]) begin
				check_value(command_ready[lane] === 1'b0,
					$sformatf("command_ready high on lane %0d after its slot loaded", lane));
			end
		end
		if (read_command_valid === 1'b1) begin
			match = -1;
			for (int i = 0; i < command_queue.size(); i++) begin
				if (match < 0 &&
					command_queue[i][entry_bits-1 -: cu_id_bits] == read_command_cu_id) begin
					match = i;
				end
			end
			if (match < 0) begin
				report_problem($sformatf("A read command left for CU %0d, which had none waiting",
					read_command_cu_id));
			end else begin
				check_value(command_queue[match][read_address_bits-1:0] === read_command_address,
					$sformatf("CU %0d read address %h, expected %h", read_command_cu_id,
					read_command_address, command_queue[match][read_address_bits-1:0]));
				command_queue.delete(match);
			end
		end
	endtask

	task automatic check_responses();
		if (response_pending) begin
			check_value(cu_response_valid === (num_cu'(1) << response_tag),
				$sformatf("cu_response_valid %b for tag %0d", cu_response_valid, response_tag));
			check_value(cu_response_data[response_tag] === response_value,
				$sformatf("response data %h on lane %0d, expected %h",
				cu_response_data[response_tag], response_tag, response_value));
		end else begin
			check_value(cu_response_valid === '0, "cu_response_valid high with no response");
		end
	endtask

	// Record what the DUT accepted this cycle
	task automatic update_model();
		for (int lane = 0; lane < num_cu; lane++) begin
			if (job_request[lane]) begin
				request_total[lane]++;
			end
		end
		if (vertex_job_valid && vertex_job_ready) begin
			job_queue.push_back(vertex_job);
		end
		// A grant pops only while the fifo holds something
		pop_pending = bus_grant && (accepted_before > pop_total);
		if (pop_pending) begin
			pop_total++;
		end
		loaded_lanes    = command_request & command_ready;
		accepted_before = accepted_total;
		for (int lane = 0; lane < num_cu; lane++) begin
			if (loaded_lanes[lane]) begin
				command_queue.push_back({cu_id_bits'(lane), command_address[lane]});
				accepted_total++;
			end
		end
		response_pending = response_valid;
		response_tag     = response_cu_id;
		response_value   = response_data;
	endtask

	task automatic check_leftovers();
		if (job_queue.size() != 0) begin
			report_problem($sformatf("%0d vertex jobs were never delivered", job_queue.size()));
		end
		if (command_queue.size() != 0) begin
			report_problem($sformatf("%0d read commands never left", command_queue.size()));
		end
	endtask

	// Inputs and outputs are both settled at the falling edge
	always @(negedge clock) begin
		if (!rstn) begin
			check_reset_state();
			clear_model();
		end else begin
			check_jobs();
			check_commands();
			check_responses();
			update_model();
			if (drain_done && !report_done) begin
				check_leftovers();
				report_done = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* tests/tb_cu_router.sv */
////////////////////////////////////////////////////////////
// Testbench top for the CU router
// Clock, reset, watchdog, stimulus table applied per cycle
// DUT and checker instances
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_cu_router;
	import cu_router_pkg::*;

	localparam int clock_period   = 100;
	localparam int drive_delay    = 10;
	localparam int reset_cycles   = 3;
	localparam int num_rows       = 110;
	localparam int stall_start    = 30;
	localparam int stall_end      = 50;
	localparam int drain_start    = 80;
	localparam int drain_allowance = 40;
	localparam logic [31:0] random_seed = 32'heaa3_492c;

	typedef struct packed {
		logic                                     push;
		logic [vertex_job_bits-1:0]               job;
		logic [num_cu-1:0]                        job_request;
		logic [num_cu-1:0]                        command_request;
		logic [num_cu-1:0][read_address_bits-1:0] address;
		logic                                     grant;
		logic                                     response_valid;
		logic [cu_id_bits-1:0]                    response_tag;
		logic [response_data_bits-1:0]            response_data;
	} stimulus_row_t;

	stimulus_row_t table_rows [num_rows];

	logic                          clock;
	logic                          rstn;
	logic                          vertex_job_valid;
	logic [vertex_job_bits-1:0]    vertex_job;
	logic                          vertex_job_ready;
	logic [num_cu-1:0]             job_request;
	logic [num_cu-1:0]             job_valid;
	logic [vertex_job_bits-1:0]    job [0:num_cu-1];
	logic [num_cu-1:0]             command_request;
	logic [read_address_bits-1:0]  command_address [0:num_cu-1];
	logic [num_cu-1:0]             command_ready;
	logic                          bus_request;
	logic                          bus_grant;
	logic                          read_command_valid;
	logic [read_address_bits-1:0]  read_command_address;
	logic [cu_id_bits-1:0]         read_command_cu_id;
	logic                          response_valid;
	logic [cu_id_bits-1:0]         response_cu_id;
	logic [response_data_bits-1:0] response_data;
	logic [num_cu-1:0]             cu_response_valid;
	logic [response_data_bits-1:0] cu_response_data [0:num_cu-1];
	logic                          drain_done;
	logic                          report_done;
	int                            error_count;
	int                            check_count;

	cu_router_top dut0 (.*);

	cu_router_checker checker0 (.*);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	initial begin
		#((reset_cycles + num_rows + drain_allowance) * clock_period);
		$display("Timeout: the run did not finish in the expected number of cycles");
		$display("Result: FAILED");
		$finish;
	end

	function automatic logic chance(input int percent);
		return int'($urandom % 100) < percent;
	endfunction

	function automatic logic [num_cu-1:0] random_bits(input int percent);
		logic [num_cu-1:0] bits;
		for (int lane = 0; lane < num_cu; lane++) begin
			bits[lane] = chance(percent);
		end
		return bits;
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////

	// Random traffic, a window with bus_grant low, then a drain
	task automatic build_table();
		stimulus_row_t entry;
		for (int row = 0; row < num_rows; row++) begin
			entry = '0;
			entry.job            = $urandom;
			entry.response_data  = $urandom;
			entry.response_tag   = cu_id_bits'($urandom % num_cu);
			entry.response_valid = chance(50);
			for (int lane = 0; lane < num_cu; lane++) begin
				entry.address[lane] = $urandom;
			end
			if (row < drain_start) begin
				entry.push        = chance(60);
				entry.job_request = random_bits(20);
				if (row >= stall_start && row < stall_end) begin
					entry.command_request = random_bits(80);
					entry.grant           = 1'b0;
				end else begin
					entry.command_request = random_bits(40);
					entry.grant           = chance(75);
				end
			end else begin
				// Every lane asks so the job fifo empties
				entry.job_request = '1;
				entry.grant       = 1'b1;
			end
			table_rows[row] = entry;
		end
	endtask

	task automatic clear_inputs();
		vertex_job_valid = 1'b0;
		vertex_job       = '0;
		job_request      = '0;
		command_request  = '0;
		bus_grant        = 1'b0;
		response_valid   = 1'b0;
		response_cu_id   = '0;
		response_data    = '0;
		for (int lane = 0; lane < num_cu; lane++) begin
			command_address[lane] = '0;
		end
	endtask

	// Pushes only go in while the matching ready is high
	task automatic apply_row(input stimulus_row_t entry);
		vertex_job_valid = entry.push && vertex_job_ready;
		vertex_job       = entry.job;
		job_request      = entry.job_request;
		command_request  = entry.command_request & command_ready;
		bus_grant        = entry.grant;
		response_valid   = entry.response_valid;
		response_cu_id   = entry.response_tag;
		response_data    = entry.response_data;
		for (int lane = 0; lane < num_cu; lane++) begin
			command_address[lane] = entry.address[lane];
		end
	endtask

	initial begin : stimulus
		rstn       = 1'b0;
		drain_done = 1'b0;
		clear_inputs();
		void'($urandom(random_seed));
		build_table();
		repeat (reset_cycles) @(posedge clock);
		#drive_delay;
		rstn = 1'b1;
		for (int row = 0; row < num_rows; row++) begin
			@(posedge clock);
			#drive_delay;
			apply_row(table_rows[row]);
		end
		// Last drain row stays applied until the slots and the burst fifo are empty
		while (bus_request || read_command_valid || command_ready !== '1) begin
			@(posedge clock);
			#drive_delay;
		end
		@(posedge clock);
		#drive_delay;
		clear_inputs();
		repeat (2) @(posedge clock);
		drain_done = 1'b1;
		wait (report_done === 1'b1);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
rtl/cu_router_pkg.sv
rtl/vertex_job_dispatch.sv
rtl/cu_port.sv
rtl/read_command_arbiter.sv
rtl/cu_router_top.sv
tests/cu_router_checker.sv
tests/tb_cu_router.sv

/* run.sh */
#!/usr/bin/env bash
# Build the CU router testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_cu_router \
	--Mdir obj_dir -o tb_cu_router || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_cu_router > sim.log 2>&1 ; cat sim.log

grep -q '^Result: PASSED$' sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
